/* src/synth_defines.svh */
`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define SAMPLE_BITS 12      // Sample, accumulator and register width
`define MANT_BITS 11        // Pitch increment, one bit below sample width
`define OCT_BITS 3          // Octave 7 means silence

// Microprogram sequencing
`define STEP_BITS 3
`define NUM_STEPS 8         // Steps per output sample

// ----------------------------------------
// Song timing
// ----------------------------------------
`define SCOUNT_BITS 16
`define SCOUNT_RESET 16'd0
// Kept small so a full track fits a short simulation
`define TRACK_LOG2_WAIT 6   // Samples per chord position, log2
`define BASS_LOG2_WAIT 4    // Samples per bass position, log2

// ALU register file
`define NUM_PHASE_REGS 3
`define REG_CHORD 0         // Chord phase
`define REG_BASS 1          // Bass phase
`define REG_OUT 2           // Mixed output sample

`endif

/* src/synth_pkg.sv */
`default_nettype none

package synth_pkg;

	// ----------------------------------------
	// Adder operand A
	// ----------------------------------------
	typedef enum logic [1:0] {
		A_ZERO,             // Constant zero
		A_ACC,              // Accumulator as is
		A_SHR1              // Accumulator >>> 1
	} a_src_e;

	// Adder operand S
	typedef enum logic [2:0] {
		S_ZERO,
		S_PHASE_CHORD,      // Chord phase register
		S_PHASE_BASS,       // Bass phase register
		S_PHASE_CHORD_HALF, // Chord phase >>> 1
		S_INC_CHORD,        // Chord mantissa, gated by oct_en
		S_INC_BASS          // Bass mantissa, gated by oct_en
	} s_src_e;

	// Voice tested on an octave enable step
	typedef enum logic {
		VOICE_CHORD,
		VOICE_BASS
	} voice_e;

	// Sequencer state
	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} ctrl_state_e;

endpackage

`default_nettype wire

/* src/synth_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "synth_defines.svh"

module synth_control (
	input  logic clk,
	input  logic reset,
	input  logic run,
	output synth_pkg::a_src_e a_src,
	output synth_pkg::s_src_e s_src,
	output logic update_acc,
	output logic update_oct_en,
	output logic step_en,
	output synth_pkg::voice_e oct_voice,
	output logic [`NUM_PHASE_REGS-1:0] dest_mask,
	output logic [`SCOUNT_BITS-1:0] sample_count,
	output logic sample_valid
);

	synth_pkg::ctrl_state_e state;
	logic [`STEP_BITS-1:0] step;    // Step executed on the next edge
	logic running;
	logic last_step;

	// Raw ROM fields, before run gating
	synth_pkg::a_src_e rom_a_src;
	synth_pkg::s_src_e rom_s_src;
	synth_pkg::voice_e rom_voice;
	logic rom_acc;
	logic rom_oct_en;
	logic [`NUM_PHASE_REGS-1:0] rom_dest;

	assign running = (state == synth_pkg::ST_RUN);
	assign last_step = (step == `STEP_BITS'(`NUM_STEPS - 1));

	// ----------------------------------------
	// Microprogram ROM
	// ----------------------------------------
	always_comb begin
		rom_a_src = synth_pkg::A_ZERO;
		rom_s_src = synth_pkg::S_ZERO;
		rom_voice = synth_pkg::VOICE_CHORD;
		rom_acc = 1'b0;
		rom_oct_en = 1'b0;
		rom_dest = '0;
		case (step)
			3'd0: begin rom_s_src = synth_pkg::S_PHASE_CHORD; rom_acc = 1'b1; end
			3'd1: rom_oct_en = 1'b1;                      // Chord octave test
			3'd2: begin
				rom_a_src = synth_pkg::A_ACC;
				rom_s_src = synth_pkg::S_INC_CHORD;
				rom_acc = 1'b1;
				rom_dest[`REG_CHORD] = 1'b1;                  // Advance chord phase
			end
			3'd3: begin rom_s_src = synth_pkg::S_PHASE_BASS; rom_acc = 1'b1; end
			3'd4: begin
				rom_voice = synth_pkg::VOICE_BASS;            // Bass octave test
				rom_oct_en = 1'b1;
			end
			3'd5: begin
				rom_a_src = synth_pkg::A_ACC;
				rom_s_src = synth_pkg::S_INC_BASS;
				rom_acc = 1'b1;
				rom_dest[`REG_BASS] = 1'b1;
			end
			3'd6: begin
				// Mix, each voice at half amplitude
				rom_a_src = synth_pkg::A_SHR1;
				rom_s_src = synth_pkg::S_PHASE_CHORD_HALF;
				rom_acc = 1'b1;
				rom_dest[`REG_OUT] = 1'b1;
			end
			default: ;                                     // Step 7 idles
		endcase
	end

	// Everything quiet outside ST_RUN
	assign a_src = running ? rom_a_src : synth_pkg::A_ZERO;
	assign s_src = running ? rom_s_src : synth_pkg::S_ZERO;
	assign oct_voice = running ? rom_voice : synth_pkg::VOICE_CHORD;
	assign update_acc = running & rom_acc;
	assign update_oct_en = running & rom_oct_en;
	assign dest_mask = running ? rom_dest : '0;
	assign step_en = running;

	// ----------------------------------------
	// State, step and sample counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= synth_pkg::ST_IDLE;
			step <= '0;
			sample_count <= `SCOUNT_RESET;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;                          // Single cycle strobe
			case (state)
				synth_pkg::ST_IDLE: begin
					step <= '0;
					if (run) state <= synth_pkg::ST_RUN;
				end
				default: begin
					step <= step + 1'b1;                   // Wraps to 0 after step 7
					if (last_step) begin
						sample_count <= sample_count + 1'b1;
						sample_valid <= 1'b1;
						if (!run) state <= synth_pkg::ST_IDLE; // Pause only between samples
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/note_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "synth_defines.svh"

module note_sequencer (
	input  logic [`SCOUNT_BITS-1:0] sample_count,
	input  logic silence,
	input  logic alt_chord,
	output logic [`MANT_BITS-1:0] chord_mant,
	output logic [`MANT_BITS-1:0] bass_mant,
	output logic [`OCT_BITS-1:0] chord_oct,
	output logic [`OCT_BITS-1:0] bass_oct
);

	localparam int TRACK_POS_BITS = 2;
	localparam int BASS_POS_BITS = 4;
	localparam logic [`OCT_BITS-1:0] OCT_SILENT = '1;

	logic [TRACK_POS_BITS-1:0] track_pos;
	logic [BASS_POS_BITS-1:0] bass_pos;
	logic [3:0] chord_semi;                                // Semitone, C = 0
	logic [3:0] bass_semi;

	// Equal temperament mantissas, top bit always set so only 7 bits kept
	function automatic logic [`MANT_BITS-1:0] mant_lookup(input logic [3:0] semi);
		logic [7:0] m;
		case (semi)
			4'd0:  m = 8'd246;
			4'd1:  m = 8'd232;
			4'd2:  m = 8'd219;
			4'd3:  m = 8'd207;
			4'd4:  m = 8'd195;
			4'd5:  m = 8'd184;
			4'd6:  m = 8'd174;
			4'd7:  m = 8'd164;
			4'd8:  m = 8'd155;
			4'd9:  m = 8'd146;
			4'd10: m = 8'd138;
			4'd11: m = 8'd130;
			default: m = 8'd0;
		endcase
		return {m[`MANT_BITS-5:0], 4'b0000};
	endfunction

	assign track_pos = sample_count[`TRACK_LOG2_WAIT +: TRACK_POS_BITS];
	assign bass_pos = sample_count[`BASS_LOG2_WAIT +: BASS_POS_BITS];

	// ----------------------------------------
	// Chord and bass tables
	// ----------------------------------------
	always_comb begin
		case (track_pos)
			2'd0: begin chord_semi = 4'd0; chord_oct = 3'd1; end  // C
			2'd1: begin chord_semi = 4'd7; chord_oct = 3'd2; end  // G
			2'd2: begin chord_semi = 4'd5; chord_oct = 3'd2; end  // F
			default: begin
				chord_semi = alt_chord ? 4'd8 : 4'd1;              // Ab or Db
				chord_oct = 3'd2;
			end
		endcase
		// Bass is the chord root, one octave down, on every fourth slot
		bass_semi = chord_semi;
		bass_oct = (bass_pos[1:0] == 2'b00) ? chord_oct + 3'd1 : OCT_SILENT;
		if (silence) begin
			chord_oct = OCT_SILENT;
			bass_oct = OCT_SILENT;
		end
	end

	assign chord_mant = mant_lookup(chord_semi);
	assign bass_mant = mant_lookup(bass_semi);

endmodule

`default_nettype wire

/* src/alu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "synth_defines.svh"

module alu_datapath (
	input  logic clk,
	input  logic reset,
	input  logic step_en,
	input  logic update_acc,
	input  logic update_oct_en,
	input  synth_pkg::a_src_e a_src,
	input  synth_pkg::s_src_e s_src,
	input  synth_pkg::voice_e oct_voice,
	input  logic [`NUM_PHASE_REGS-1:0] dest_mask,
	input  logic [`SCOUNT_BITS-1:0] sample_count,
	input  logic [`MANT_BITS-1:0] chord_mant,
	input  logic [`MANT_BITS-1:0] bass_mant,
	input  logic [`OCT_BITS-1:0] chord_oct,
	input  logic [`OCT_BITS-1:0] bass_oct,
	output logic signed [`SAMPLE_BITS-1:0] out
);

	localparam int NUM_OCTS = 2 ** `OCT_BITS;

	logic [`SAMPLE_BITS-1:0] acc;
	logic [`SAMPLE_BITS-1:0] regs [`NUM_PHASE_REGS];   // Chord phase, bass phase, output
	logic oct_en;                                      // Voice steps on this sample

	logic [`SAMPLE_BITS-1:0] a_val;
	logic [`SAMPLE_BITS-1:0] s_val;
	logic [`SAMPLE_BITS-1:0] sum;
	logic [`OCT_BITS-1:0] cur_oct;
	logic [NUM_OCTS-1:0] oct_enables;

	// ----------------------------------------
	// Operand selection
	// ----------------------------------------
	always_comb begin
		case (a_src)
			synth_pkg::A_ACC:  a_val = acc;
			synth_pkg::A_SHR1: a_val = {acc[`SAMPLE_BITS-1], acc[`SAMPLE_BITS-1:1]};
			default:           a_val = '0;
		endcase
	end

	always_comb begin
		case (s_src)
			synth_pkg::S_PHASE_CHORD: s_val = regs[`REG_CHORD];
			synth_pkg::S_PHASE_BASS:  s_val = regs[`REG_BASS];
			synth_pkg::S_PHASE_CHORD_HALF: begin
				// Sign kept so the mix stays centred
				s_val = {regs[`REG_CHORD][`SAMPLE_BITS-1], regs[`REG_CHORD][`SAMPLE_BITS-1:1]};
			end
			synth_pkg::S_INC_CHORD: s_val = oct_en ? {1'b0, chord_mant} : '0;
			synth_pkg::S_INC_BASS:  s_val = oct_en ? {1'b0, bass_mant} : '0;
			default:                s_val = '0;
		endcase
	end

	assign sum = a_val + s_val;                       // Wraps, phase is modular

	// ----------------------------------------
	// Octave enable
	// ----------------------------------------
	// Octave o steps once every 2**o samples, octave 7 never
	always_comb begin
		cur_oct = (oct_voice == synth_pkg::VOICE_BASS) ? bass_oct : chord_oct;
		oct_enables = '0;
		oct_enables[0] = 1'b1;
		for (int o = 1; o < NUM_OCTS - 1; o++) begin
			oct_enables[o] = oct_enables[o-1] & ~sample_count[o-1];
		end
	end

	// ----------------------------------------
	// State update
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			oct_en <= 1'b0;
		end else if (step_en) begin
			if (update_acc) acc <= sum;
			if (update_oct_en) oct_en <= oct_enables[cur_oct];
		end
	end

	// Masked register writes take the same sum as acc
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_PHASE_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (step_en) begin
			for (int i = 0; i < `NUM_PHASE_REGS; i++) begin
				if (dest_mask[i]) regs[i] <= sum;
			end
		end
	end

	assign out = regs[`REG_OUT];                      // Holds between step 6 writes

endmodule

`default_nettype wire

/* src/synth_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "synth_defines.svh"

module synth_top (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic silence,
	input  logic alt_chord,
	output logic signed [`SAMPLE_BITS-1:0] out,
	output logic sample_valid
);

	// Control to datapath
	synth_pkg::a_src_e a_src;
	synth_pkg::s_src_e s_src;
	synth_pkg::voice_e oct_voice;
	logic update_acc;
	logic update_oct_en;
	logic step_en;
	logic [`NUM_PHASE_REGS-1:0] dest_mask;
	logic [`SCOUNT_BITS-1:0] sample_count;

	// Notes, combinational from sample_count
	logic [`MANT_BITS-1:0] chord_mant;
	logic [`MANT_BITS-1:0] bass_mant;
	logic [`OCT_BITS-1:0] chord_oct;
	logic [`OCT_BITS-1:0] bass_oct;

	synth_control u_control (
		.clk(clk), .reset(reset), .run(run),
		.a_src(a_src), .s_src(s_src),
		.update_acc(update_acc), .update_oct_en(update_oct_en), .step_en(step_en),
		.oct_voice(oct_voice), .dest_mask(dest_mask),
		.sample_count(sample_count), .sample_valid(sample_valid)
	);

	note_sequencer u_notes (
		.sample_count(sample_count), .silence(silence), .alt_chord(alt_chord),
		.chord_mant(chord_mant), .bass_mant(bass_mant),
		.chord_oct(chord_oct), .bass_oct(bass_oct)
	);

	alu_datapath u_alu (
		.clk(clk), .reset(reset), .step_en(step_en),
		.update_acc(update_acc), .update_oct_en(update_oct_en),
		.a_src(a_src), .s_src(s_src), .oct_voice(oct_voice),
		.dest_mask(dest_mask), .sample_count(sample_count),
		.chord_mant(chord_mant), .bass_mant(bass_mant),
		.chord_oct(chord_oct), .bass_oct(bass_oct),
		.out(out)
	);

endmodule

`default_nettype wire

/* verification/tb_synth.sv */
`timescale 1ns/1ps
`default_nettype none
`include "synth_defines.svh"

module tb_synth;

	localparam int STROBE_TIMEOUT = 40;   // Falling edges before a strobe counts as lost
	localparam int FIRST_LATENCY = 9;     // Falling edges from run driven high to first strobe
	localparam int SAMPLE_PERIOD = `NUM_STEPS;

	// Note table per track position
	localparam logic [3:0] CHORD_SEMI [4] = '{4'd0, 4'd7, 4'd5, 4'd1};   // C G F Db
	localparam logic [2:0] CHORD_OCT [4] = '{3'd1, 3'd2, 3'd2, 3'd2};
	localparam int MANT_TABLE [12] = '{246, 232, 219, 207, 195, 184, 174, 164, 155, 146, 138, 130};

	logic clk;
	logic reset;
	logic run;
	logic silence;
	logic alt_chord;
	logic [`SAMPLE_BITS-1:0] out;
	logic sample_valid;

	int errors;
	int checks;
	int seed;

	// Reference model state
	logic [`SAMPLE_BITS-1:0] m_chord;
	logic [`SAMPLE_BITS-1:0] m_bass;
	logic [`SCOUNT_BITS-1:0] m_count;      // Completed samples

	synth_top uut (
		.clk(clk), .reset(reset), .run(run),
		.silence(silence), .alt_chord(alt_chord),
		.out(out), .sample_valid(sample_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;               // 4 ns period
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	// Increment truncated to its field width
	function automatic logic [`MANT_BITS-1:0] note_inc(input logic [3:0] semi);
		return `MANT_BITS'(MANT_TABLE[semi] << 4);
	endfunction

	// Octave o steps when the low o bits of the count are zero
	function automatic logic oct_steps(input logic [2:0] oct, input logic [`SCOUNT_BITS-1:0] n);
		if (oct == 3'd7)
			return 1'b0;                     // Silent voice
		return (n & ((`SCOUNT_BITS'(1) << oct) - `SCOUNT_BITS'(1))) == '0;
	endfunction

	function automatic logic [`SAMPLE_BITS-1:0] half(input logic [`SAMPLE_BITS-1:0] x);
		return `SAMPLE_BITS'($signed(x) >>> 1);   // Arithmetic shift
	endfunction

	// Both model phases at half amplitude
	function automatic logic [`SAMPLE_BITS-1:0] model_mix();
		return half(m_bass) + half(m_chord);
	endfunction

	// Advance both phases by one sample and mix
	task automatic advance_model(output logic [`SAMPLE_BITS-1:0] expected);
		logic [1:0] track_pos;
		logic [3:0] bass_pos;
		logic [3:0] semi;
		logic [2:0] chord_oct;
		logic [2:0] bass_oct;
		track_pos = m_count[`TRACK_LOG2_WAIT +: 2];
		bass_pos = m_count[`BASS_LOG2_WAIT +: 4];
		semi = CHORD_SEMI[track_pos];
		if (track_pos == 2'd3 && alt_chord)
			semi = 4'd8;                     // Ab
		chord_oct = CHORD_OCT[track_pos];
		bass_oct = (bass_pos[1:0] == 2'b00) ? chord_oct + 3'd1 : 3'd7;   // Root an octave down
		if (silence) begin
			chord_oct = 3'd7;
			bass_oct = 3'd7;
		end
		if (oct_steps(chord_oct, m_count))
			m_chord = m_chord + `SAMPLE_BITS'(note_inc(semi));
		if (oct_steps(bass_oct, m_count))
			m_bass = m_bass + `SAMPLE_BITS'(note_inc(semi));
		expected = model_mix();
		m_count = m_count + `SCOUNT_BITS'(1);
	endtask

	// ----------------------------------------
	// Checking and waiting
	// ----------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	// Counts falling edges up to the strobe
	task automatic wait_strobe(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!sample_valid && cycles < STROBE_TIMEOUT);
		if (!sample_valid) begin
			errors++;
			$display("ERROR t=%0t timeout waiting for sample_valid", $time);
			finish_run();
		end
	endtask

	task automatic sample_and_check(output int cycles);
		logic [`SAMPLE_BITS-1:0] expected;
		wait_strobe(cycles);
		advance_model(expected);
		check_value("out", 32'(expected), 32'(out));
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic reset_behavior();
		repeat (4) begin
			@(negedge clk);
			check_value("sample_valid", 0, 32'(sample_valid));
			check_value("out", 0, 32'(out));
		end
		reset = 1'b0;
		repeat (16) begin                     // Run still low so nothing moves
			@(negedge clk);
			check_value("sample_valid", 0, 32'(sample_valid));
			check_value("out", 0, 32'(out));
		end
	endtask

	task automatic strobe_timing();
		int cycles;
		run = 1'b1;
		sample_and_check(cycles);
		check_value("first strobe latency", FIRST_LATENCY, cycles);
		repeat (19) begin
			sample_and_check(cycles);
			check_value("strobe period", SAMPLE_PERIOD, cycles);
		end
	endtask

	task automatic normal_playback();
		int cycles;
		repeat (8 << `TRACK_LOG2_WAIT) begin  // Two full tracks
			sample_and_check(cycles);
			check_value("strobe period", SAMPLE_PERIOD, cycles);
		end
	endtask

	task automatic alternate_chord();
		int cycles;
		alt_chord = 1'b1;                     // Changed right after a strobe
		repeat (4 << `TRACK_LOG2_WAIT) begin
			sample_and_check(cycles);
		end
		alt_chord = 1'b0;
	endtask

	task automatic silence_freeze();
		int cycles;
		logic [`SAMPLE_BITS-1:0] held;
		silence = 1'b1;
		held = model_mix();
		repeat (64) begin
			sample_and_check(cycles);
			check_value("out held", 32'(held), 32'(out));   // Frozen phases
		end
		silence = 1'b0;
	endtask

	task automatic pause_and_resume();
		int cycles;
		int delay;
		logic [`SAMPLE_BITS-1:0] held;
		delay = 1 + (($random(seed) & 32'h7fff_ffff) % 6);   // Lands before step 7
		repeat (delay) @(negedge clk);
		run = 1'b0;
		sample_and_check(cycles);             // Current pass still finishes
		check_value("strobe period", SAMPLE_PERIOD - delay, cycles);
		held = model_mix();
		repeat (5 * SAMPLE_PERIOD) begin
			@(negedge clk);
			check_value("sample_valid", 0, 32'(sample_valid));
			check_value("out held", 32'(held), 32'(out));
		end
		run = 1'b1;
		sample_and_check(cycles);
		check_value("restart latency", FIRST_LATENCY, cycles);
		repeat (15) sample_and_check(cycles);
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		silence = 1'b0;
		alt_chord = 1'b0;
		errors = 0;
		checks = 0;
		seed = 32;
		m_chord = '0;
		m_bass = '0;
		m_count = '0;
		reset_behavior();
		strobe_timing();
		normal_playback();
		alternate_chord();
		silence_freeze();
		pause_and_resume();
		finish_run();
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/synth_pkg.sv
src/synth_control.sv
src/note_sequencer.sv
src/alu_datapath.sv
src/synth_top.sv
verification/tb_synth.sv

/* Makefile */
SIM      = verilator
TOP      = tb_synth
FILELIST = vlog.f
FLAGS    = --binary --timing --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) src/synth_defines.svh

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
